// File: Bender.yml
package:
  name: rom_check

sources:
  - files:
      - logic/rom_check_pkg.sv
      - logic/rom_word_if.sv
      - logic/rom_scanner.sv
      - logic/digest_lane.sv
      - logic/digest_compare.sv
      - logic/rom_check_top.sv
  - target: test
    files:
      - tests/rom_check_assert.sv
      - tests/rom_check_monitor.sv
      - tests/rom_check_tb.sv

// File: logic/digest_compare.sv
// **************************************************
// Compares the computed digest with the stored one,
// one word per cycle, then reports a multi-bit result.
// **************************************************
module digest_compare #(
  parameter int NumWords = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,

  input  logic                                        start_i,
  input  logic                                        scan_done_i,

  // Word 0 in the low bits
  input  logic [NumWords*rom_check_pkg::WordWidth-1:0] digest_i,
  input  logic [NumWords*rom_check_pkg::WordWidth-1:0] exp_digest_i,

  output logic                                        done_o,
  output rom_check_pkg::check_result_e                good_o,
  // Sticky control-flow alert
  output logic                                        alert_o
);

  localparam int W    = rom_check_pkg::WordWidth;
  localparam int IdxW = (NumWords > 1) ? $clog2(NumWords) : 1;

  localparam logic [IdxW-1:0] LastIdx = IdxW'(NumWords - 1);

  rom_check_pkg::cmp_state_e state_q, state_d;
  logic [IdxW-1:0]           idx_q;
  logic                      idx_incr;
  logic                      matches_q;
  // A start has been seen for this run
  logic                      armed_q;
  logic                      alert_q;

  logic [W-1:0]              digest_word;
  logic [W-1:0]              exp_word;

  logic                      fsm_alert;
  logic                      start_alert;
  logic                      wait_idx_alert;
  logic                      done_idx_alert;
  logic                      scan_alert;

  // Waiting, then Checking for NumWords cycles, then Done for good
  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    case (state_q)
      rom_check_pkg::CmpWaiting: begin
        if (scan_done_i) begin
          state_d = rom_check_pkg::CmpChecking;
        end
      end
      rom_check_pkg::CmpChecking: begin
        if (idx_q == LastIdx) begin
          state_d = rom_check_pkg::CmpDone;
        end
      end
      rom_check_pkg::CmpDone: begin
        // Final
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  // Step through words, stop on the last one
  assign idx_incr = (state_q == rom_check_pkg::CmpChecking) && (idx_q != LastIdx);

  // Current word pair
  assign digest_word = digest_i[idx_q*W +: W];
  assign exp_word    = exp_digest_i[idx_q*W +: W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= rom_check_pkg::CmpWaiting;
      idx_q     <= '0;
      matches_q <= 1'b1;
      armed_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (idx_incr) begin
        idx_q <= idx_q + 1'b1;
      end
      // Any mismatch clears it for good
      if (state_q == rom_check_pkg::CmpChecking) begin
        matches_q <= matches_q && (digest_word == exp_word);
      end
      if (start_i && (state_q == rom_check_pkg::CmpWaiting)) begin
        armed_q <= 1'b1;
      end
    end
  end

  // Only one start per run, and only while waiting
  assign start_alert = start_i && ((state_q != rom_check_pkg::CmpWaiting) || armed_q);

  // Index must sit at zero before checking
  assign wait_idx_alert = (state_q == rom_check_pkg::CmpWaiting) && (idx_q != '0);

  // Index must rest on the last word once done
  assign done_idx_alert = (state_q == rom_check_pkg::CmpDone) && (idx_q != LastIdx);

  // Scan end is only legal while waiting
  assign scan_alert = scan_done_i && (state_q != rom_check_pkg::CmpWaiting);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | fsm_alert | start_alert | wait_idx_alert |
                 done_idx_alert | scan_alert;
    end
  end

  assign alert_o = alert_q;
  assign done_o  = (state_q == rom_check_pkg::CmpDone);

  // True only after a full clean pass
  assign good_o = (done_o && matches_q) ? rom_check_pkg::ResultTrue
                                        : rom_check_pkg::ResultFalse;

endmodule

// File: logic/digest_lane.sv
// **************************************************
// One digest word accumulated over the payload stream.
// LaneIdx picks the rotate amount, so lanes differ.
// **************************************************
module digest_lane #(
  parameter int LaneIdx = 0
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Payload stream from the scanner
  rom_word_if.lane                            word_i,

  output logic [rom_check_pkg::WordWidth-1:0] digest_o
);

  localparam int W = rom_check_pkg::WordWidth;

  // Rotate by LaneIdx+1, wrapped to the word width
  localparam int RotAmt = (LaneIdx + 1) % W;

  localparam logic [W-1:0] Seed = rom_check_pkg::LaneSeedBase ^ W'(LaneIdx);

  logic [W-1:0] acc_q;
  logic [W-1:0] acc_rot;
  logic [W-1:0] acc_next;
  // Set once the final payload word is folded in
  logic         sealed_q;
  logic         update;

  // Left rotate of the running value
  assign acc_rot = (acc_q << RotAmt) | (acc_q >> (W - RotAmt));

  // Rotate, xor the word, add the index
  assign acc_next = (acc_rot ^ word_i.word_data) + W'(word_i.word_index);

  // No further updates after the last word
  assign update = word_i.word_valid && !sealed_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q    <= Seed;
      sealed_q <= 1'b0;
    end else begin
      if (update) begin
        acc_q <= acc_next;
        if (word_i.word_last) begin
          sealed_q <= 1'b1;
        end
      end
    end
  end

  assign digest_o = acc_q;

endmodule

// File: logic/rom_check_pkg.sv
// **************************************************
// Shared constants and types for the ROM checker.
// Referenced by scoped name from every RTL module.
// **************************************************
package rom_check_pkg;

  // ROM word and digest word width
  parameter int unsigned WordWidth = 32;

  // Multi-bit check result
  // Any other pattern is treated as invalid
  typedef enum logic [3:0] {
    ResultTrue  = 4'h6,
    ResultFalse = 4'h9
  } check_result_e;

  // Scanner sequencing
  typedef enum logic [1:0] {
    ScanIdle = 2'd0,
    ScanRead = 2'd1,
    ScanDone = 2'd2
  } scan_state_e;

  // Comparator sequencing
  typedef enum logic [1:0] {
    CmpWaiting  = 2'd0,
    CmpChecking = 2'd1,
    CmpDone     = 2'd2
  } cmp_state_e;

  // Base seed for the digest lanes
  // Lane k starts at this value xor k
  parameter logic [WordWidth-1:0] LaneSeedBase = 32'h9e3779b9;

endpackage

// File: logic/rom_check_top.sv
// **************************************************
// ROM integrity checker top level. Pulse start_i once,
// then wait for done_o and read good_o and alert_o.
// **************************************************
module rom_check_top #(
  parameter int RomDepth = 32,
  parameter int NumWords = 2
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  input  logic                                start_i,

  // External ROM, one-cycle read latency
  output logic                                rom_req_o,
  output logic [$clog2(RomDepth)-1:0]         rom_addr_o,
  input  logic [rom_check_pkg::WordWidth-1:0] rom_rdata_i,

  // Result
  output logic                                done_o,
  output rom_check_pkg::check_result_e        good_o,
  output logic                                alert_o
);

  localparam int W     = rom_check_pkg::WordWidth;
  localparam int AddrW = $clog2(RomDepth);

  logic                  scan_done;
  logic [NumWords*W-1:0] exp_digest;
  // Lane k fills slot k
  logic [NumWords*W-1:0] digest;

  // Payload stream, scanner to all lanes
  rom_word_if #(
    .IdxWidth(AddrW)
  ) word_if ();

  rom_scanner #(
    .RomDepth(RomDepth),
    .NumWords(NumWords)
  ) u_scanner (
    .clk_i,
    .rst_ni,
    .start_i,
    .rom_req_o,
    .rom_addr_o,
    .rom_rdata_i,
    .word_o       (word_if.source),
    .scan_done_o  (scan_done),
    .exp_digest_o (exp_digest)
  );

  // One lane per digest word
  for (genvar k = 0; k < NumWords; k++) begin : g_lane
    digest_lane #(
      .LaneIdx(k)
    ) u_lane (
      .clk_i,
      .rst_ni,
      .word_i   (word_if.lane),
      .digest_o (digest[k*W +: W])
    );
  end

  digest_compare #(
    .NumWords(NumWords)
  ) u_compare (
    .clk_i,
    .rst_ni,
    .start_i,
    .scan_done_i  (scan_done),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .done_o,
    .good_o,
    .alert_o
  );

endmodule

// File: logic/rom_scanner.sv
// **************************************************
// Reads every ROM word once after start_i, streams the
// payload to the lanes and captures the stored digest.
// **************************************************
module rom_scanner #(
  parameter int RomDepth = 32,
  parameter int NumWords = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  input  logic                                  start_i,

  // ROM read port, data one cycle after request
  output logic                                  rom_req_o,
  output logic [$clog2(RomDepth)-1:0]           rom_addr_o,
  input  logic [rom_check_pkg::WordWidth-1:0]   rom_rdata_i,

  // Payload stream to the lanes
  rom_word_if.source                            word_o,

  // To the comparator
  output logic                                  scan_done_o,
  output logic [NumWords*rom_check_pkg::WordWidth-1:0] exp_digest_o
);

  localparam int W      = rom_check_pkg::WordWidth;
  localparam int AddrW  = $clog2(RomDepth);
  // First address holding an expected digest word
  localparam int PayloadLimit = RomDepth - NumWords;

  localparam logic [AddrW-1:0] LastAddr  = AddrW'(RomDepth - 1);
  localparam logic [AddrW-1:0] LimitAddr = AddrW'(PayloadLimit);
  localparam logic [AddrW-1:0] LastPay   = AddrW'(PayloadLimit - 1);

  rom_check_pkg::scan_state_e state_q, state_d;
  logic [AddrW-1:0]           addr_q, addr_d;

  // Tag of the word currently on rom_rdata_i
  logic                       rsp_valid_q;
  logic [AddrW-1:0]           rsp_addr_q;

  logic [NumWords*W-1:0]      exp_q;

  // Read sequencing; runs once per reset
  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    case (state_q)
      rom_check_pkg::ScanIdle: begin
        // Later start pulses are ignored here
        if (start_i) begin
          state_d = rom_check_pkg::ScanRead;
        end
      end
      rom_check_pkg::ScanRead: begin
        if (addr_q == LastAddr) begin
          state_d = rom_check_pkg::ScanDone;
        end else begin
          addr_d = addr_q + 1'b1;
        end
      end
      rom_check_pkg::ScanDone: begin
        // Final
      end
      default: begin
        state_d = rom_check_pkg::ScanDone;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= rom_check_pkg::ScanIdle;
      addr_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      addr_q      <= addr_d;
      rsp_valid_q <= rom_req_o;
    end
  end

  // Address tag follows the request by one cycle
  always_ff @(posedge clk_i) begin
    rsp_addr_q <= addr_q;
  end

  assign rom_req_o  = (state_q == rom_check_pkg::ScanRead);
  assign rom_addr_o = addr_q;

  // Payload words go straight onto the stream
  assign word_o.word_valid = rsp_valid_q && (rsp_addr_q < LimitAddr);
  assign word_o.word_data  = rom_rdata_i;
  assign word_o.word_index = rsp_addr_q;
  assign word_o.word_last  = (rsp_addr_q == LastPay);

  // Top words land in their digest slot, word 0 lowest
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NumWords; k++) begin
      if (rsp_valid_q && (rsp_addr_q == LimitAddr + AddrW'(k))) begin
        exp_q[k*W +: W] <= rom_rdata_i;
      end
    end
  end

  assign exp_digest_o = exp_q;

  // High while the last ROM word is on the bus
  assign scan_done_o = rsp_valid_q && (rsp_addr_q == LastAddr);

endmodule

// File: logic/rom_word_if.sv
// **************************************************
// Payload word stream from the ROM scanner.
// Scanner drives source, each digest lane takes lane.
// **************************************************
interface rom_word_if #(
  parameter int IdxWidth = 5
);

  // One-cycle strobe per payload word
  logic                                  word_valid;
  // Payload word as read from the ROM
  logic [rom_check_pkg::WordWidth-1:0]   word_data;
  // Payload index, equal to the ROM address
  logic [IdxWidth-1:0]                   word_index;
  // Set together with the final payload word
  logic                                  word_last;

  // Producer side
  modport source (
    output word_valid,
    output word_data,
    output word_index,
    output word_last
  );

  // Consumer side, one per lane
  modport lane (
    input word_valid,
    input word_data,
    input word_index,
    input word_last
  );

endinterface

// File: rom_check_top.f
logic/rom_check_pkg.sv
logic/rom_word_if.sv
logic/rom_scanner.sv
logic/digest_lane.sv
logic/digest_compare.sv
logic/rom_check_top.sv
tests/rom_check_assert.sv
tests/rom_check_monitor.sv
tests/rom_check_tb.sv

// File: tests/rom_check_assert.sv
// **************************************************
// Concurrent checks on the digest comparator outputs.
// Bound into every digest_compare instance below.
// **************************************************
module rom_check_assert (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         done_i,
  input rom_check_pkg::check_result_e good_i
);

  // Failed assertions, read by the testbench at the end
  int fail_count;

  // Done is final until the next reset
  done_sticky: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |=> done_i
  ) else begin
    fail_count++;
    $error("done_o fell while reset was released");
  end

  // Only the two legal result encodings
  good_encoding: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (good_i == rom_check_pkg::ResultTrue) || (good_i == rom_check_pkg::ResultFalse)
  ) else begin
    fail_count++;
    $error("good_o holds an invalid result encoding");
  end

  // A true result needs a finished check
  good_needs_done: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (good_i == rom_check_pkg::ResultTrue) |-> done_i
  ) else begin
    fail_count++;
    $error("good_o reports true before done_o is set");
  end

endmodule

bind digest_compare rom_check_assert u_assert (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .done_i (done_o),
  .good_i (good_o)
);

// File: tests/rom_check_monitor.sv
// **************************************************
// Watches the DUT outputs, compares them per test and
// keeps the pass and fail counts for the testbench.
// **************************************************
module rom_check_monitor (
  input  logic                         clk_i,

  // DUT outputs
  input  logic                         done_i,
  input  logic                         rom_req_i,
  input  rom_check_pkg::check_result_e good_i,
  input  logic                         alert_i,

  // Test request from the testbench
  input  logic                         req_i,
  input  logic                         idle_mode_i,
  input  logic [8*24-1:0]              name_i,
  input  rom_check_pkg::check_result_e exp_good_i,
  input  logic                         exp_alert_i,

  output int                           checks_done_o,
  output int                           pass_cnt_o,
  output int                           fail_cnt_o
);

  logic test_ok;

  // One field of one test
  task automatic compare_field(input logic [8*24-1:0] name, input logic [8*8-1:0] field,
                               input logic [3:0] expected, input logic [3:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %0s %0s: expected %0h, actual %0h",
               name, field, expected, actual);
      test_ok = 1'b0;
    end
  endtask

  // Sample on the falling edge, away from the DUT updates
  initial begin
    checks_done_o = 0;
    pass_cnt_o    = 0;
    fail_cnt_o    = 0;
    test_ok       = 1'b1;
    forever begin
      @(negedge clk_i);
      if (req_i) begin
        test_ok = 1'b1;
        if (idle_mode_i) begin
          // Quiet outputs straight after reset
          compare_field(name_i, "done", 4'h0, {3'b000, done_i});
          compare_field(name_i, "alert", 4'h0, {3'b000, alert_i});
          compare_field(name_i, "rom_req", 4'h0, {3'b000, rom_req_i});
          compare_field(name_i, "good", rom_check_pkg::ResultFalse, good_i);
        end else begin
          // Run ends when done rises
          while (!done_i) begin
            @(negedge clk_i);
          end
          compare_field(name_i, "good", exp_good_i, good_i);
          compare_field(name_i, "alert", {3'b000, exp_alert_i}, {3'b000, alert_i});
        end
        if (test_ok) begin
          pass_cnt_o++;
          $display("test %0d %0s: PASS", checks_done_o, name_i);
        end else begin
          fail_cnt_o++;
          $display("test %0d %0s: FAIL", checks_done_o, name_i);
        end
        checks_done_o++;
        // Hold off until the request drops
        while (req_i) begin
          @(negedge clk_i);
        end
      end
    end
  end

endmodule

// File: tests/rom_check_tb.sv
// **************************************************
// Testbench for the ROM checker with a ROM model,
// reference digest, directed and random images.
// **************************************************
module rom_check_tb;

  localparam int RomDepth = 32;
  localparam int NumWords = 2;
  localparam int W        = 32;
  localparam int AddrW    = $clog2(RomDepth);
  // Reset check, four directed, eight random
  localparam int NumTests = 13;
  localparam int TimeoutCycles = NumTests * (RomDepth + NumWords + 40) * 2;

  logic                         clk;
  logic                         rst_n;
  logic                         start;
  logic                         rom_req;
  logic [AddrW-1:0]             rom_addr;
  logic [W-1:0]                 rom_rdata;
  logic                         done;
  rom_check_pkg::check_result_e good;
  logic                         alert;

  logic [W-1:0]                 rom_mem [RomDepth];
  integer                       seed;

  // Monitor request
  logic                         mon_req;
  logic                         mon_idle;
  logic [8*24-1:0]              mon_name;
  rom_check_pkg::check_result_e mon_exp_good;
  logic                         mon_exp_alert;
  int                           checks_done;
  int                           pass_cnt;
  int                           fail_cnt;

  always #5 clk = ~clk;

  rom_check_top #(
    .RomDepth(RomDepth),
    .NumWords(NumWords)
  ) u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .start_i     (start),
    .rom_req_o   (rom_req),
    .rom_addr_o  (rom_addr),
    .rom_rdata_i (rom_rdata),
    .done_o      (done),
    .good_o      (good),
    .alert_o     (alert)
  );

  rom_check_monitor u_monitor (
    .clk_i         (clk),
    .done_i        (done),
    .rom_req_i     (rom_req),
    .good_i        (good),
    .alert_i       (alert),
    .req_i         (mon_req),
    .idle_mode_i   (mon_idle),
    .name_i        (mon_name),
    .exp_good_i    (mon_exp_good),
    .exp_alert_i   (mon_exp_alert),
    .checks_done_o (checks_done),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  // ROM answers one cycle after the request
  always @(posedge clk) begin
    if (rom_req) begin
      rom_rdata <= rom_mem[rom_addr];
    end
  end

  function automatic logic [W-1:0] rotl(input logic [W-1:0] v, input int amt);
    return (v << amt) | (v >> (W - amt));
  endfunction

  // Lane k starts at seed xor k, then rotates by k+1, xors the word and adds the index
  function automatic logic [NumWords*W-1:0] ref_digest();
    logic [NumWords*W-1:0] dig;
    logic [W-1:0]          acc;
    for (int k = 0; k < NumWords; k++) begin
      acc = 32'h9e3779b9 ^ W'(k);
      for (int i = 0; i < RomDepth - NumWords; i++) begin
        acc = (rotl(acc, (k + 1) % W) ^ rom_mem[i]) + W'(i);
      end
      dig[k*W +: W] = acc;
    end
    return dig;
  endfunction

  // Top words of the image with word 0 lowest
  function automatic logic [NumWords*W-1:0] stored_digest();
    logic [NumWords*W-1:0] dig;
    for (int k = 0; k < NumWords; k++) begin
      dig[k*W +: W] = rom_mem[RomDepth - NumWords + k];
    end
    return dig;
  endfunction

  task automatic fill_pattern();
    for (int a = 0; a < RomDepth; a++) begin
      rom_mem[a] = 32'hc3a50f1e ^ (32'(a) * 32'h9e3779b1);
    end
  endtask

  task automatic fill_random();
    for (int a = 0; a < RomDepth; a++) begin
      rom_mem[a] = $random(seed);
    end
  endtask

  task automatic store_digest();
    logic [NumWords*W-1:0] dig;
    dig = ref_digest();
    for (int k = 0; k < NumWords; k++) begin
      rom_mem[RomDepth - NumWords + k] = dig[k*W +: W];
    end
  endtask

  // Flips one bit in any word of the image
  task automatic flip_random_bit();
    logic [31:0] r;
    r = $random(seed);
    rom_mem[r[15:0] % RomDepth] = rom_mem[r[15:0] % RomDepth] ^ (32'h1 << r[20:16]);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic check_reset_state();
    int target;
    target = checks_done + 1;
    apply_reset();
    @(posedge clk);
    mon_name <= "reset_state";
    mon_idle <= 1'b1;
    mon_req  <= 1'b1;
    wait (checks_done == target);
    @(posedge clk);
    mon_req  <= 1'b0;
  endtask

  // One full scan with an optional second start pulse mid-scan
  task automatic run_check(input logic [8*24-1:0] name, input logic exp_alert,
                           input logic second_start);
    rom_check_pkg::check_result_e exp_good;
    int                           target;
    exp_good = (ref_digest() == stored_digest()) ? rom_check_pkg::ResultTrue
                                                 : rom_check_pkg::ResultFalse;
    target = checks_done + 1;
    apply_reset();
    @(posedge clk);
    mon_name      <= name;
    mon_idle      <= 1'b0;
    mon_exp_good  <= exp_good;
    mon_exp_alert <= exp_alert;
    mon_req       <= 1'b1;
    start         <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (second_start) begin
      repeat (4) @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    wait (checks_done == target);
    @(posedge clk);
    mon_req <= 1'b0;
  endtask

  initial begin
    seed          = 32'hbb59;
    clk           = 1'b0;
    rst_n         = 1'b0;
    start         = 1'b0;
    rom_rdata     = '0;
    mon_req       = 1'b0;
    mon_idle      = 1'b0;
    mon_name      = '0;
    mon_exp_good  = rom_check_pkg::ResultFalse;
    mon_exp_alert = 1'b0;

    check_reset_state();

    fill_pattern();
    store_digest();
    run_check("digest_match", 1'b0, 1'b0);

    // Stored digest word off by one bit
    rom_mem[RomDepth-1] = rom_mem[RomDepth-1] ^ 32'h0000_0080;
    run_check("digest_word_flip", 1'b0, 1'b0);

    fill_pattern();
    store_digest();
    rom_mem[5] = rom_mem[5] ^ 32'h0000_1000;
    run_check("payload_flip", 1'b0, 1'b0);

    fill_pattern();
    store_digest();
    run_check("second_start", 1'b1, 1'b1);

    // Even runs clean, odd runs corrupted
    for (int t = 0; t < 8; t++) begin
      fill_random();
      store_digest();
      if (t % 2 == 1) begin
        flip_random_bit();
      end
      run_check((t % 2 == 1) ? "random_corrupt" : "random_good", 1'b0, 1'b0);
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", checks_done, pass_cnt, fail_cnt);
    if ((fail_cnt == 0) && (checks_done == NumTests) &&
        (u_dut.u_compare.u_assert.fail_count == 0)) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule
